//--- minx_pkg.sv
package minx_pkg;

    // Video RAM window seen by the CPU
    localparam logic [15:0] vram_base  = 16'h1000;
    localparam int          vram_bytes = 256;

    // Display RAM window of the LCD controller
    localparam logic [15:0] lcd_base = 16'h2100;

    // Control registers
    localparam logic [15:0] reg_ctrl   = 16'h2000; // Bit 0 starts a frame copy
    localparam logic [15:0] reg_status = 16'h2001; // Bit 0 is busy
    localparam logic [15:0] reg_length = 16'h2002; // Bytes to copy minus one

    typedef struct packed {
        logic [15:0] paddr;
        logic        pwrite;
        logic [7:0]  pwdata;
        logic        psel;
        logic        penable;
    } apb_req_t;

    typedef enum logic [2:0] {
        region_vram,
        region_ctrl,
        region_status,
        region_length,
        region_lcd,
        region_none
    } region_e;

endpackage

//--- prc_pkg.sv
package prc_pkg;

    // Largest frame the PRC copies, also the display RAM size
    localparam int frame_bytes_max = 256;

    typedef enum logic [1:0] {
        idle,
        request,  // Waiting for bus_ack
        transfer, // Issuing video RAM reads
        drain     // Waiting for the LCD side to finish
    } prc_state_e;

    // One byte on its way to display RAM
    typedef struct packed {
        logic [7:0] index;
        logic [7:0] data;
        logic       last;
    } copy_beat_t;

endpackage

//--- apb_reg_bank.sv
module apb_reg_bank
(
    input  logic               clk,
    input  logic               reset,
    input  minx_pkg::apb_req_t apb,
    output logic [7:0]         prdata,
    output logic               pready,

    output logic               vram_sel,
    output logic               vram_we,
    output logic [7:0]         vram_addr,
    output logic [7:0]         vram_wdata,
    input  logic [7:0]         vram_rdata,
    input  logic               vram_ready,

    output logic               start,
    output logic [7:0]         frame_length,
    input  logic               busy,

    output logic [7:0]         lcd_addr,
    input  logic [7:0]         lcd_rdata
);

    minx_pkg::region_e region;
    logic              access;
    logic [7:0]        length_q;

    always_comb begin
        if (apb.paddr[15:8] == minx_pkg::vram_base[15:8])
            region = minx_pkg::region_vram;
        else if (apb.paddr[15:8] == minx_pkg::lcd_base[15:8])
            region = minx_pkg::region_lcd;
        else if (apb.paddr == minx_pkg::reg_ctrl)
            region = minx_pkg::region_ctrl;
        else if (apb.paddr == minx_pkg::reg_status)
            region = minx_pkg::region_status;
        else if (apb.paddr == minx_pkg::reg_length)
            region = minx_pkg::region_length;
        else
            region = minx_pkg::region_none;
    end

    assign access = apb.psel & apb.penable;

    // Video RAM accesses wait on the arbiter, everything else is immediate
    assign pready = access & ((region != minx_pkg::region_vram) | vram_ready);

    assign vram_sel   = access & (region == minx_pkg::region_vram);
    assign vram_we    = apb.pwrite;
    assign vram_addr  = apb.paddr[7:0];
    assign vram_wdata = apb.pwdata;
    assign lcd_addr   = apb.paddr[7:0];

    assign start = access & apb.pwrite & (region == minx_pkg::region_ctrl)
                 & apb.pwdata[0] & ~busy; // Dropped while a copy runs

    always_ff @(posedge clk) begin
        if (reset)
            length_q <= '0;
        else if (access && apb.pwrite && region == minx_pkg::region_length)
            length_q <= apb.pwdata;
    end

    assign frame_length = length_q;

    always_comb begin
        case (region)
            minx_pkg::region_vram:   prdata = vram_rdata;
            minx_pkg::region_lcd:    prdata = lcd_rdata;
            minx_pkg::region_status: prdata = {7'b0, busy};
            minx_pkg::region_length: prdata = length_q;
            default:                 prdata = 8'h00; // Control is write-only
        endcase
    end

endmodule

//--- vram_arbiter.sv
module vram_arbiter
(
    input  logic       clk,
    input  logic       reset,

    input  logic       vram_sel,
    input  logic       vram_we,
    input  logic [7:0] vram_addr,
    input  logic [7:0] vram_wdata,
    output logic [7:0] vram_rdata,
    output logic       vram_ready,

    input  logic       bus_request,
    output logic       bus_ack,
    input  logic       prc_rd_en,
    input  logic [7:0] prc_addr,
    output logic [7:0] prc_rdata
);

    logic [7:0] mem [minx_pkg::vram_bytes];
    logic [7:0] rdata_q;
    logic [7:0] ram_addr;
    logic       cpu_phase;
    logic       cpu_start;
    logic       ram_rd;

    // CPU may only begin while the PRC neither asks for nor holds the bus
    assign cpu_start = vram_sel & ~cpu_phase & ~bus_request & ~bus_ack;

    assign ram_rd   = (cpu_start & ~vram_we) | (prc_rd_en & bus_ack);
    assign ram_addr = bus_ack ? prc_addr : vram_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            cpu_phase <= 1'b0;
            bus_ack   <= 1'b0;
        end else begin
            cpu_phase <= cpu_start;   // Second access cycle completes the CPU access
            bus_ack   <= bus_request; // Requests are blocked from starting CPU work
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_start && vram_we)
            mem[vram_addr] <= vram_wdata;
        if (ram_rd)
            rdata_q <= mem[ram_addr];
    end

    assign vram_ready = cpu_phase;
    assign vram_rdata = rdata_q;
    assign prc_rdata  = rdata_q;

endmodule

//--- prc_frame_reader.sv
module prc_frame_reader
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [7:0]          frame_length,
    output logic                busy,

    output logic                bus_request,
    input  logic                bus_ack,
    output logic                prc_rd_en,
    output logic [7:0]          prc_addr,
    input  logic [7:0]          prc_rdata,

    output logic                push,
    output prc_pkg::copy_beat_t push_beat,
    input  logic                full,
    input  logic                irq_frame_copy
);

    prc_pkg::prc_state_e state;
    prc_pkg::copy_beat_t ret_beat;
    prc_pkg::copy_beat_t hold_beat;
    logic [7:0]          length_q;
    logic [7:0]          addr_q;
    logic [7:0]          rd_index;
    logic                rd_last;
    logic                rd_pending;
    logic                hold_valid;
    logic                accept;
    logic                issue;

    assign busy        = (state != prc_pkg::idle) & ~irq_frame_copy;
    assign accept      = start & ~busy;
    assign bus_request = (state == prc_pkg::request) | (state == prc_pkg::transfer);

    // No new read while the hold slot is taken, so a returning byte always has a place
    assign issue     = (state == prc_pkg::transfer) & bus_ack & ~full & ~hold_valid;
    assign prc_rd_en = issue;
    assign prc_addr  = addr_q;

    assign ret_beat  = '{index: rd_index, data: prc_rdata, last: rd_last};
    assign push      = ~full & (hold_valid | rd_pending);
    assign push_beat = hold_valid ? hold_beat : ret_beat;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= prc_pkg::idle;
            rd_pending <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            rd_pending <= issue;
            if (rd_pending && full)
                hold_valid <= 1'b1;
            else if (hold_valid && !full)
                hold_valid <= 1'b0;

            case (state)
                prc_pkg::idle:     if (accept) state <= prc_pkg::request;
                prc_pkg::request:  if (bus_ack) state <= prc_pkg::transfer;
                prc_pkg::transfer: if (issue && addr_q == length_q) state <= prc_pkg::drain;
                prc_pkg::drain:    if (irq_frame_copy)
                                       state <= accept ? prc_pkg::request : prc_pkg::idle;
                default:           state <= prc_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            length_q <= frame_length;
            addr_q   <= '0;
        end else if (issue) begin
            addr_q <= addr_q + 8'd1;
        end
        if (issue) begin
            rd_index <= addr_q;
            rd_last  <= (addr_q == length_q);
        end
        if (rd_pending && full)
            hold_beat <= ret_beat; // Byte returned into a full FIFO
    end

endmodule

//--- copy_fifo.sv
module copy_fifo
#(
    parameter int fifo_depth = 8
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  prc_pkg::copy_beat_t push_beat,
    output logic                full,
    input  logic                pop,
    output prc_pkg::copy_beat_t pop_beat,
    output logic                empty
);

    localparam int              aw         = $clog2(fifo_depth);
    localparam logic [aw:0]     full_count = (aw + 1)'(fifo_depth);

    prc_pkg::copy_beat_t mem [fifo_depth];
    logic [aw-1:0]       wr_ptr;
    logic [aw-1:0]       rd_ptr;
    logic [aw:0]         count;
    logic                do_push;
    logic                do_pop;

    assign full     = (count == full_count);
    assign empty    = (count == '0);
    assign do_push  = push & ~full;
    assign do_pop   = pop & ~empty;
    assign pop_beat = mem[rd_ptr]; // Head shown without a wait

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_beat;
    end

endmodule

//--- lcd_controller.sv
module lcd_controller
(
    input  logic                clk,
    input  logic                reset,

    output logic                pop,
    input  prc_pkg::copy_beat_t pop_beat,
    input  logic                empty,

    input  logic [7:0]          lcd_addr,
    output logic [7:0]          lcd_rdata,
    output logic                irq_frame_copy
);

    logic [7:0] mem [prc_pkg::frame_bytes_max];
    logic       irq_q;

    // Always ready, one beat per cycle
    assign pop = ~empty;

    always_ff @(posedge clk) begin
        if (pop)
            mem[pop_beat.index] <= pop_beat.data;
    end

    always_ff @(posedge clk) begin
        if (reset)
            irq_q <= 1'b0;
        else
            irq_q <= pop & pop_beat.last; // Frame is complete once the last byte lands
    end

    assign irq_frame_copy = irq_q;

    // CPU read-back path
    assign lcd_rdata = mem[lcd_addr];

endmodule

//--- minx_video.sv
module minx_video
#(
    parameter int fifo_depth = 8
)
(
    input  logic               clk,
    input  logic               reset,
    input  minx_pkg::apb_req_t apb,
    output logic [7:0]         prdata,
    output logic               pready,
    output logic               irq_frame_copy
);

    logic                vram_sel;
    logic                vram_we;
    logic [7:0]          vram_addr;
    logic [7:0]          vram_wdata;
    logic [7:0]          vram_rdata;
    logic                vram_ready;
    logic                start;
    logic [7:0]          frame_length;
    logic                busy;
    logic [7:0]          lcd_addr;
    logic [7:0]          lcd_rdata;

    logic                bus_request;
    logic                bus_ack;
    logic                prc_rd_en;
    logic [7:0]          prc_addr;
    logic [7:0]          prc_rdata;

    logic                push;
    logic                full;
    logic                pop;
    logic                empty;
    prc_pkg::copy_beat_t push_beat;
    prc_pkg::copy_beat_t pop_beat;

    apb_reg_bank regs
    (
        .clk          (clk),
        .reset        (reset),
        .apb          (apb),
        .prdata       (prdata),
        .pready       (pready),
        .vram_sel     (vram_sel),
        .vram_we      (vram_we),
        .vram_addr    (vram_addr),
        .vram_wdata   (vram_wdata),
        .vram_rdata   (vram_rdata),
        .vram_ready   (vram_ready),
        .start        (start),
        .frame_length (frame_length),
        .busy         (busy),
        .lcd_addr     (lcd_addr),
        .lcd_rdata    (lcd_rdata)
    );

    vram_arbiter vram
    (
        .clk         (clk),
        .reset       (reset),
        .vram_sel    (vram_sel),
        .vram_we     (vram_we),
        .vram_addr   (vram_addr),
        .vram_wdata  (vram_wdata),
        .vram_rdata  (vram_rdata),
        .vram_ready  (vram_ready),
        .bus_request (bus_request),
        .bus_ack     (bus_ack),
        .prc_rd_en   (prc_rd_en),
        .prc_addr    (prc_addr),
        .prc_rdata   (prc_rdata)
    );

    prc_frame_reader prc
    (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .frame_length   (frame_length),
        .busy           (busy),
        .bus_request    (bus_request),
        .bus_ack        (bus_ack),
        .prc_rd_en      (prc_rd_en),
        .prc_addr       (prc_addr),
        .prc_rdata      (prc_rdata),
        .push           (push),
        .push_beat      (push_beat),
        .full           (full),
        .irq_frame_copy (irq_frame_copy)
    );

    copy_fifo #(.fifo_depth(fifo_depth)) fifo
    (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_beat (push_beat),
        .full      (full),
        .pop       (pop),
        .pop_beat  (pop_beat),
        .empty     (empty)
    );

    lcd_controller lcd
    (
        .clk            (clk),
        .reset          (reset),
        .pop            (pop),
        .pop_beat       (pop_beat),
        .empty          (empty),
        .lcd_addr       (lcd_addr),
        .lcd_rdata      (lcd_rdata),
        .irq_frame_copy (irq_frame_copy)
    );

endmodule

//--- minx_video_props.sv
module minx_video_props
(
    input logic               clk,
    input logic               reset,
    input logic               push,
    input logic               empty,
    input logic               irq_frame_copy,
    input logic               bus_ack,
    input logic               pready,
    input minx_pkg::apb_req_t apb
);
    timeunit 1ns;
    timeprecision 1ps;

    push_lands: assert property (@(posedge clk) disable iff (reset) push |=> !empty)
        else $error("Beat pushed into the copy FIFO did not arrive");

    irq_one_cycle: assert property (@(posedge clk) disable iff (reset)
        irq_frame_copy |=> !irq_frame_copy)
        else $error("Frame copy interrupt longer than one cycle");

    // Video RAM needs a second access cycle and never completes under the PRC grant
    vram_ready_late: assert property (@(posedge clk) disable iff (reset)
        pready && apb.paddr[15:8] == minx_pkg::vram_base[15:8]
        |-> !bus_ack && $past(apb.psel && apb.penable))
        else $error("Video RAM access completed in its first access cycle or under bus_ack");

endmodule

bind minx_video minx_video_props props_inst (.clk(clk), .reset(reset), .push(push),
    .empty(empty), .irq_frame_copy(irq_frame_copy), .bus_ack(bus_ack), .pready(pready),
    .apb(apb));

//--- minx_video_checker.sv
module minx_video_checker
(
    input  logic               clk,
    input  logic               reset,
    input  minx_pkg::apb_req_t apb,
    input  logic [7:0]         prdata,
    input  logic               pready,
    input  logic               irq_frame_copy,
    input  logic [7:0]         exp_rdata,
    input  logic               exp_check,
    input  logic               test_done,
    input  int                 test_id,
    input  int                 exp_irqs,
    output int                 passes,
    output int                 fails
);
    timeunit 1ns;
    timeprecision 1ps;

    int errors;
    int irqs;

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset state and unmapped reads";
            2:       return "video RAM write and read-back";
            3:       return "frame copy into display RAM";
            4:       return "CPU reads during a copy";
            5:       return "start while busy";
            6:       return "display RAM beyond the length";
            default: return "unknown";
        endcase
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            errors = 0;
            irqs   = 0;
            passes <= 0;
            fails  <= 0;
        end else begin
            // Read data is valid in the completing access cycle
            if (apb.psel && apb.penable && pready && exp_check && prdata !== exp_rdata) begin
                $display("ERROR at %0t: prdata (paddr %h) expected %h, got %h",
                         $time, apb.paddr, exp_rdata, prdata);
                errors++;
            end
            if (irq_frame_copy)
                irqs++;
            if (test_done) begin
                if (irqs != exp_irqs) begin
                    $display("Test %0d saw %0d frame copy interrupts where %0d were due",
                             test_id, irqs, exp_irqs);
                    errors++;
                end
                $display("Test %0d %s: %s", test_id, test_name(test_id),
                         (errors == 0) ? "pass" : "fail");
                if (errors == 0)
                    passes <= passes + 1;
                else
                    fails <= fails + 1;
                errors = 0;
                irqs   = 0;
            end
        end
    end

endmodule

//--- tb_minx_video.sv
module tb_minx_video;
    timeunit 1ns;
    timeprecision 1ps;

    // Each frame copy costs a length write, two control writes, status polls and a read-back
    localparam int     planned_xfers = 8 + 320 + 32 + 5 * 480;
    localparam longint timeout_ns    = longint'(planned_xfers) * 300 * 20;

    logic               clk = 1'b0;
    logic               reset;
    minx_pkg::apb_req_t apb;
    logic [7:0]         prdata;
    logic               pready;
    logic               irq_frame_copy;
    logic [7:0]         exp_rdata;
    logic               exp_check;
    logic               test_done;
    int                 test_id;
    int                 exp_irqs;
    int                 passes;
    int                 fails;
    logic [31:0]        lfsr = 32'h6c9a_c5c8;
    logic [7:0]         vram_model [256];
    logic [7:0]         lcd_model [256];
    logic               lcd_known [256]; // Display RAM is not cleared by reset
    logic [7:0]         len;
    logic [7:0]         a;
    logic [15:0]        ua;

    always #10 clk = ~clk;

    minx_video #(.fifo_depth(4)) minx_video_inst (.clk(clk), .reset(reset), .apb(apb),
        .prdata(prdata), .pready(pready), .irq_frame_copy(irq_frame_copy));

    minx_video_checker check_inst (.clk(clk), .reset(reset), .apb(apb), .prdata(prdata),
        .pready(pready), .irq_frame_copy(irq_frame_copy), .exp_rdata(exp_rdata),
        .exp_check(exp_check), .test_done(test_done), .test_id(test_id),
        .exp_irqs(exp_irqs), .passes(passes), .fails(fails));

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[6:0], fb};
        end
        return r;
    endfunction

    task automatic apb_xfer(input logic [15:0] addr, input logic wr, input logic [7:0] wdata,
                            input logic chk, input logic [7:0] exp, output logic [7:0] rdata);
        @(posedge clk);
        apb       <= '{paddr: addr, pwrite: wr, pwdata: wdata, psel: 1'b1, penable: 1'b0};
        exp_rdata <= exp;
        exp_check <= chk & ~wr;
        @(posedge clk);
        apb.penable <= 1'b1;
        @(posedge clk);
        while (!pready)
            @(posedge clk); // Video RAM stalls while the PRC owns the bus
        rdata = prdata;
        apb.psel    <= 1'b0;
        apb.penable <= 1'b0;
        exp_check   <= 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] rd;
        apb_xfer(addr, 1'b1, data, 1'b0, 8'h00, rd);
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [7:0] exp, input logic chk);
        logic [7:0] rd;
        apb_xfer(addr, 1'b0, 8'h00, chk, exp, rd);
    endtask

    task automatic fill_vram();
        logic [7:0] d;
        for (int i = 0; i < 256; i++) begin
            d = rand_bits(8);
            write_reg(minx_pkg::vram_base + 16'(i), d);
            vram_model[i] = d;
        end
    endtask

    task automatic wait_idle();
        logic [7:0] st;
        do
            apb_xfer(minx_pkg::reg_status, 1'b0, 8'h00, 1'b0, 8'h00, st);
        while (st[0]);
    endtask

    task automatic start_copy(input logic [7:0] length);
        write_reg(minx_pkg::reg_length, length);
        write_reg(minx_pkg::reg_ctrl, 8'h01);
        for (int i = 0; i <= int'(length); i++) begin
            lcd_model[i] = vram_model[i];
            lcd_known[i] = 1'b1;
        end
    endtask

    task automatic check_lcd();
        for (int i = 0; i < 256; i++)
            read_check(minx_pkg::lcd_base + 16'(i), lcd_model[i], lcd_known[i]);
    endtask

    task automatic end_test(input int id, input int irqs);
        repeat (4) @(posedge clk);
        test_done <= 1'b1;
        test_id   <= id;
        exp_irqs  <= irqs;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    initial begin
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns", timeout_ns);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        apb       = '0;
        exp_rdata = '0;
        exp_check = 1'b0;
        test_done = 1'b0;
        test_id   = 0;
        exp_irqs  = 0;
        for (int i = 0; i < 256; i++)
            lcd_known[i] = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        read_check(minx_pkg::reg_status, 8'h00, 1'b1);
        read_check(minx_pkg::reg_ctrl, 8'h00, 1'b1);
        for (int i = 0; i < 4; i++) begin
            ua = {1'b1, 7'(rand_bits(7)), rand_bits(8)}; // Always above the mapped windows
            read_check(ua, 8'h00, 1'b1);
        end
        end_test(1, 0);

        fill_vram();
        for (int i = 0; i < 64; i++) begin
            a = rand_bits(8);
            read_check(minx_pkg::vram_base + 16'(a), vram_model[a], 1'b1);
        end
        end_test(2, 0);

        start_copy(8'hff);
        read_check(minx_pkg::reg_status, 8'h01, 1'b1);
        wait_idle();
        check_lcd();
        fill_vram();
        len = rand_bits(8);
        start_copy(len);
        wait_idle();
        read_check(minx_pkg::reg_length, len, 1'b1);
        check_lcd();
        end_test(3, 2);

        start_copy(rand_bits(8) | 8'h80);
        for (int i = 0; i < 32; i++) begin
            a = rand_bits(8);
            read_check(minx_pkg::vram_base + 16'(a), vram_model[a], 1'b1);
        end
        wait_idle();
        end_test(4, 1);

        start_copy(rand_bits(8) | 8'h40);
        write_reg(minx_pkg::reg_ctrl, 8'h01); // Ignored while the copy runs
        read_check(minx_pkg::reg_status, 8'h01, 1'b1);
        wait_idle();
        repeat (40) @(posedge clk);
        end_test(5, 1);

        fill_vram();
        start_copy(rand_bits(7));
        wait_idle();
        check_lcd();
        end_test(6, 1);

        repeat (3) @(posedge clk);
        $display("Tests passed %0d, failed %0d", passes, fails);
        if (fails == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- project.f
minx_pkg.sv
prc_pkg.sv
apb_reg_bank.sv
vram_arbiter.sv
prc_frame_reader.sv
copy_fifo.sv
lcd_controller.sv
minx_video.sv
minx_video_props.sv
minx_video_checker.sv
tb_minx_video.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_minx_video
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove build output and the log"
	@echo "Variables: VERILATOR TOP LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f project.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
